// File: bench/exu_model.svh
`ifndef EXU_MODEL_SVH
`define EXU_MODEL_SVH

`include "exu_macros.svh"

// byte lanes of every data memory word, updated in completion order
logic [7:0] shadow_mem [0:`EXU_DMEM_WORDS-1][0:`EXU_WORD_BYTES-1];

task automatic model_clear();
	for (int w = 0; w < `EXU_DMEM_WORDS; w++)
		for (int b = 0; b < `EXU_WORD_BYTES; b++)
			shadow_mem[w][b] = 8'h00;
endtask

// expected writeback of one request, applies its store to the shadow memory
function automatic exu_pkg::wb_t model_exec(input exu_pkg::exu_req_t req);
	exu_pkg::wb_t wb;
	logic [31:0] a;
	logic [31:0] b;
	logic [31:0] res;
	logic [4:0] sh;
	logic cond;
	logic [$clog2(`EXU_DMEM_WORDS)-1:0] widx;
	logic [1:0] off;
	logic [7:0] lane [0:3];
	int nbytes;
	a = req.src1;
	b = req.src2;
	sh = b[4:0];
	res = 0;
	cond = 1'b0;
	case (req.alu_op)
		exu_pkg::ALU_ADD: res = req.is_jalr ? (req.ecall ? req.pc : req.pc + `EXU_WORD_BYTES) : a + b;
		exu_pkg::ALU_SUB: res = a - b;
		exu_pkg::ALU_SLL: res = a << sh;
		exu_pkg::ALU_SLT: res = ($signed(a) < $signed(b)) ? 1 : 0;
		exu_pkg::ALU_SLTU: res = (a < b) ? 1 : 0;
		exu_pkg::ALU_XOR: res = a ^ b;
		exu_pkg::ALU_SRL: res = a >> sh;
		exu_pkg::ALU_SRA: res = $signed(a) >>> sh;
		exu_pkg::ALU_OR: res = a | b;
		exu_pkg::ALU_AND: res = a & b;
		exu_pkg::ALU_EQ: cond = (a == b);
		exu_pkg::ALU_NEQ: cond = (a != b);
		exu_pkg::ALU_LT: cond = $signed(a) < $signed(b);
		exu_pkg::ALU_GE: cond = $signed(a) >= $signed(b);
		exu_pkg::ALU_LTU: cond = a < b;
		default: cond = a >= b; // geu
	endcase
	widx = res[2 +: $clog2(`EXU_DMEM_WORDS)];
	off = res[1:0];
	for (int k = 0; k < 4; k++)
		lane[k] = (off + k < 4) ? shadow_mem[widx][off + k] : 8'h00; // past the word reads zero
	wb.rd = req.rd;
	wb.reg_write = req.reg_write;
	wb.taken = cond || req.is_jump;
	wb.target = (req.is_jalr || req.mret) ? a + b : req.pc + req.imm;
	wb.ecall = req.ecall;
	wb.mret = req.mret;
	wb.fence_i = req.fence_i;
	case (req.load_kind)
		exu_pkg::LD_LB: wb.wdata = {{24{lane[0][7]}}, lane[0]};
		exu_pkg::LD_LH: wb.wdata = {{16{lane[1][7]}}, lane[1], lane[0]};
		exu_pkg::LD_LW: wb.wdata = {lane[3], lane[2], lane[1], lane[0]};
		exu_pkg::LD_LBU: wb.wdata = {24'h0, lane[0]};
		exu_pkg::LD_LHU: wb.wdata = {16'h0, lane[1], lane[0]};
		default: wb.wdata = res;
	endcase
	// store lands after the load view, lanes past the word are lost
	nbytes = (req.store_kind == exu_pkg::ST_SB) ? 1 :
		(req.store_kind == exu_pkg::ST_SH) ? 2 :
		(req.store_kind == exu_pkg::ST_SW) ? 4 : 0;
	for (int k = 0; k < nbytes; k++)
		if (off + k < 4)
			shadow_mem[widx][off + k] = req.store_data[8*k +: 8];
	return wb;
endfunction

`endif

// File: bench/exu_tb.sv
`timescale 1ns/100ps
`include "exu_macros.svh"

module exu_tb;

	logic clk;
	logic reset;
	logic in_valid;
	logic in_ready;
	exu_pkg::exu_req_t in_req;
	logic out_valid;
	logic out_ready;
	exu_pkg::wb_t out_wb;

	exu_pkg::exu_req_t stim_req[$];
	string stim_name[$];
	exu_pkg::exu_req_t exp_req[$]; // accepted, not yet written back
	string exp_name[$];

	int n_total = 0;
	int n_done = 0;
	int n_pass = 0;
	int n_fail = 0;
	logic in_fire_s = 1'b0;

	`include "exu_model.svh"

	exu_top u_exu_top (
		.clk       (clk),
		.reset     (reset),
		.in_valid  (in_valid),
		.in_ready  (in_ready),
		.in_req    (in_req),
		.out_valid (out_valid),
		.out_ready (out_ready),
		.out_wb    (out_wb)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	task automatic check_wb(input string name, input exu_pkg::wb_t exp, input exu_pkg::wb_t act);
		if (act === exp) begin
			n_pass++;
			$display("[PASS] %s", name);
		end else begin
			n_fail++;
			$display("[FAIL] %s expected %h actual %h", name, exp, act);
		end
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		if (act === exp) begin
			n_pass++;
			$display("[PASS] %s", name);
		end else begin
			n_fail++;
			$display("[FAIL] %s expected %b actual %b", name, exp, act);
		end
	endtask

	// random operands and pass-through fields, no jump, load or store
	function automatic exu_pkg::exu_req_t random_req();
		exu_pkg::exu_req_t r;
		r = '0;
		r.pc = $urandom & 32'hffff_fffc;
		r.src1 = $urandom;
		r.src2 = $urandom;
		r.imm = $urandom;
		r.store_data = $urandom;
		r.rd = 5'($urandom);
		r.reg_write = 1'($urandom);
		r.ecall = 1'($urandom);
		r.mret = 1'($urandom);
		r.fence_i = 1'($urandom);
		return r;
	endfunction

	task automatic add_stim(input string name, input exu_pkg::exu_req_t r);
		stim_req.push_back(r);
		stim_name.push_back(name);
	endtask

	task automatic build_stimulus();
		exu_pkg::exu_req_t r;
		exu_pkg::alu_op_e op;
		exu_pkg::store_kind_e sk;
		logic [31:0] addr;
		for (int i = 0; i < 16; i++) begin
			op = exu_pkg::alu_op_e'(i);
			r = random_req();
			r.alu_op = op;
			add_stim({op.name(), " random"}, r);
			r.src1 = 32'h8000_0000; // sign bit, shift by 31
			r.src2 = 32'h0000_001f;
			add_stim({op.name(), " sign edge"}, r);
			r.src1 = 32'h7fff_ffff;
			r.src2 = (i < 10) ? 32'hffff_ffe1 : 32'h7fff_ffff; // equal operands for compares
			add_stim({op.name(), " max edge"}, r);
		end
		for (int j = 0; j < 2; j++) begin
			r = random_req();
			r.alu_op = exu_pkg::ALU_ADD;
			r.is_jump = 1'b1;
			r.ecall = 1'b0;
			r.mret = 1'b0;
			add_stim("jal", r);
			r.is_jalr = 1'b1;
			add_stim("jalr", r);
			r.ecall = 1'b1;
			add_stim("jalr with ecall", r);
			r.ecall = 1'b0;
			r.is_jalr = 1'b0;
			r.mret = 1'b1;
			add_stim("mret", r);
		end
		for (int s = 1; s <= 3; s++) begin
			sk = exu_pkg::store_kind_e'(s);
			for (int off = 0; off < 4; off++) begin
				addr = $urandom;
				addr[1:0] = 2'(off);
				r = random_req();
				r.mret = 1'b0;
				r.store_kind = sk;
				r.src2 = addr - r.src1;
				add_stim($sformatf("store %s offset %0d", sk.name(), off), r);
				for (int lk = 1; lk <= 5; lk++) begin
					for (int lo = 0; lo < 4; lo++) begin
						r = random_req();
						r.load_kind = exu_pkg::load_kind_e'(lk);
						r.src2 = {addr[31:2], 2'(lo)} - r.src1;
						add_stim($sformatf("%s after %s offset %0d", r.load_kind.name(),
							sk.name(), lo), r);
					end
				end
			end
		end
	endtask

	task automatic accept(input int idx);
		exp_req.push_back(stim_req[idx]);
		exp_name.push_back(stim_name[idx]);
	endtask

	// samples between edges, transfers happen on the following rising edge
	always @(negedge clk) begin : compare_outputs
		exu_pkg::wb_t exp;
		in_fire_s = !reset && in_valid && in_ready;
		if (!reset && out_valid && out_ready) begin
			if (exp_req.size() == 0) begin
				n_fail++;
				$display("error: a writeback arrived with no request pending");
			end else begin
				exp = model_exec(exp_req.pop_front());
				check_wb(exp_name.pop_front(), exp, out_wb);
				n_done++;
			end
		end
	end

	initial begin : drive
		int idx;
		void'($urandom(32'ha859dc3f));
		reset = 1'b1;
		in_valid = 1'b0;
		out_ready = 1'b0;
		in_req = '0;
		model_clear();
		build_stimulus();
		n_total = stim_req.size();
		repeat (8) @(posedge clk);
		reset <= 1'b0;
		// lone request through an idle pipeline
		@(posedge clk);
		in_req <= stim_req[0];
		in_valid <= 1'b1;
		out_ready <= 1'b1;
		@(negedge clk);
		check_flag("in_ready after reset", 1'b1, in_ready);
		check_flag("out_valid after reset", 1'b0, out_valid);
		@(posedge clk);
		accept(0);
		idx = 1;
		in_valid <= 1'b0;
		@(negedge clk);
		check_flag("no output one edge after accept", 1'b0, out_valid);
		@(negedge clk);
		check_flag("output two edges after accept", 1'b1, out_valid);
		while (idx < n_total) begin
			@(posedge clk);
			if (in_fire_s) begin
				accept(idx);
				idx++;
			end
			out_ready <= ($urandom_range(0, 99) < 60);
			if (!in_valid || in_fire_s) begin
				if (idx < n_total && $urandom_range(0, 99) < 75) begin
					in_req <= stim_req[idx];
					in_valid <= 1'b1;
				end else begin
					in_valid <= 1'b0;
				end
			end
		end
		@(posedge clk);
		out_ready <= 1'b1; // drain
		wait (n_done == n_total);
		repeat (3) @(negedge clk);
		check_flag("no extra writeback", 1'b0, out_valid);
		$display("%0d checks passed, %0d failed", n_pass, n_fail);
		if (n_fail == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

	initial begin : watchdog
		wait (n_total > 0);
		repeat (20 * n_total + 40) @(posedge clk);
		$display("timeout: outputs stopped arriving, %0d of %0d writebacks seen", n_done, n_total);
		$display("CHECKS FAILED");
		$finish;
	end

endmodule

// File: filelist.f
+incdir+src
+incdir+bench
src/exu_pkg.sv
src/exu_execute.sv
src/stage_reg.sv
src/lsu_dmem.sv
src/exu_ctrl.sv
src/exu_top.sv
bench/exu_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the execute/memory testbench with verilator
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --top-module exu_tb -f filelist.f -Mdir obj_dir -o exu_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/exu_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "CHECKS FAILED" "$LOG"; then
	exit 1
fi
exit 0

// File: src/exu_ctrl.sv
`timescale 1ns/100ps

module exu_ctrl (
	input  logic clk,
	input  logic reset,
	input  logic in_valid,
	output logic in_ready,
	output logic out_valid,
	input  logic out_ready,
	output logic ex_load,
	output logic mem_load,
	output logic commit
);

	logic ex_valid;
	logic mem_valid;
	logic out_fire;
	logic mem_adv;
	logic ex_adv;

	assign out_fire = mem_valid && out_ready;
	assign mem_adv = !mem_valid || out_fire; // mem stage free next edge
	assign ex_adv = !ex_valid || mem_adv;

	// low only with both stages full and the output stalled
	assign in_ready = ex_adv;
	assign out_valid = mem_valid;

	assign ex_load = in_valid && in_ready;
	assign mem_load = ex_valid && mem_adv;
	assign commit = out_fire;

	always_ff @(posedge clk) begin
		if (reset) begin
			ex_valid <= 1'b0;
			mem_valid <= 1'b0;
		end else begin
			if (mem_adv)
				mem_valid <= ex_valid; // bubble moves down when ex is empty
			if (ex_adv)
				ex_valid <= in_valid;
		end
	end

endmodule

// File: src/exu_execute.sv
`timescale 1ns/100ps
`include "exu_macros.svh"

module exu_execute (
	input  exu_pkg::exu_req_t   req,
	output exu_pkg::mem_stage_t mem
);

	localparam int SHAMT_W = $clog2(`EXU_XLEN);

	exu_pkg::word_t result;
	exu_pkg::word_t link;
	exu_pkg::word_t target;
	logic cond;
	logic lt_s;
	logic lt_u;
	logic [SHAMT_W-1:0] shamt;

	assign shamt = req.src2[SHAMT_W-1:0]; // only low bits shift
	assign lt_s = $signed(req.src1) < $signed(req.src2);
	assign lt_u = req.src1 < req.src2;

	// ecall rides the jalr path but keeps its own pc
	assign link = req.ecall ? req.pc : req.pc + `EXU_WORD_BYTES;

	// register-relative for jalr and mret
	assign target = (req.is_jalr || req.mret) ? req.src1 + req.src2 : req.pc + req.imm;

	always_comb begin
		result = '0;
		cond = 1'b0;
		case (req.alu_op)
			exu_pkg::ALU_ADD: begin
				if (req.is_jalr)
					result = link;
				else
					result = req.src1 + req.src2; // also load/store address
			end
			exu_pkg::ALU_SUB: begin
				result = req.src1 - req.src2;
			end
			exu_pkg::ALU_SLL: begin
				result = req.src1 << shamt;
			end
			exu_pkg::ALU_SLT: begin
				result = exu_pkg::word_t'(lt_s);
			end
			exu_pkg::ALU_SLTU: begin
				result = exu_pkg::word_t'(lt_u);
			end
			exu_pkg::ALU_XOR: begin
				result = req.src1 ^ req.src2;
			end
			exu_pkg::ALU_SRL: begin
				result = req.src1 >> shamt;
			end
			exu_pkg::ALU_SRA: begin
				result = $signed(req.src1) >>> shamt; // keeps sign
			end
			exu_pkg::ALU_OR: begin
				result = req.src1 | req.src2;
			end
			exu_pkg::ALU_AND: begin
				result = req.src1 & req.src2;
			end
			// compares only set the branch condition, result stays zero
			exu_pkg::ALU_EQ: begin
				cond = req.src1 == req.src2;
			end
			exu_pkg::ALU_NEQ: begin
				cond = req.src1 != req.src2;
			end
			exu_pkg::ALU_LT: begin
				cond = lt_s;
			end
			exu_pkg::ALU_GE: begin
				cond = !lt_s;
			end
			exu_pkg::ALU_LTU: begin
				cond = lt_u;
			end
			exu_pkg::ALU_GEU: begin
				cond = !lt_u;
			end
			default: begin
				result = '0;
				cond = 1'b0;
			end
		endcase
	end

	assign mem.result = result;
	assign mem.store_data = req.store_data;
	assign mem.rd = req.rd;
	assign mem.reg_write = req.reg_write;
	assign mem.load_kind = req.load_kind;
	assign mem.store_kind = req.store_kind;
	assign mem.taken = cond || req.is_jump; // jumps always redirect
	assign mem.target = target;
	assign mem.ecall = req.ecall;
	assign mem.mret = req.mret;
	assign mem.fence_i = req.fence_i;

endmodule

// File: src/exu_macros.svh
`ifndef EXU_MACROS_SVH
`define EXU_MACROS_SVH

// width of operands, results and addresses
`define EXU_XLEN 32

// instruction size in bytes, used for the link address
`define EXU_WORD_BYTES 4

// data memory depth in words
// index taken from the address bits above the byte offset, wraps around
`define EXU_DMEM_WORDS 256

`endif

// File: src/exu_pkg.sv
`include "exu_macros.svh"

package exu_pkg;

	typedef logic [`EXU_XLEN-1:0] word_t;
	typedef logic [4:0] reg_idx_t; // x0..x31

	// arithmetic ops first, compare ops in the upper part
	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_SLL,
		ALU_SLT,
		ALU_SLTU,
		ALU_XOR,
		ALU_SRL,
		ALU_SRA,
		ALU_OR,
		ALU_AND,
		ALU_EQ,
		ALU_NEQ,
		ALU_LT,
		ALU_GE,
		ALU_LTU,
		ALU_GEU
	} alu_op_e;

	typedef enum logic [2:0] {
		LD_NONE,
		LD_LB,
		LD_LH,
		LD_LW,
		LD_LBU,
		LD_LHU
	} load_kind_e;

	typedef enum logic [1:0] {
		ST_NONE,
		ST_SB,
		ST_SH,
		ST_SW
	} store_kind_e;

	// request from decode
	typedef struct packed {
		word_t pc;
		word_t src1;
		word_t src2;
		word_t imm;
		word_t store_data;
		alu_op_e alu_op;
		reg_idx_t rd;
		logic reg_write;
		logic is_jump;
		logic is_jalr;
		logic ecall;
		logic mret;
		logic fence_i;
		load_kind_e load_kind;
		store_kind_e store_kind;
	} exu_req_t;

	// execute -> memory stage
	typedef struct packed {
		word_t result; // alu value or memory address
		word_t store_data;
		reg_idx_t rd;
		logic reg_write;
		load_kind_e load_kind;
		store_kind_e store_kind;
		logic taken;
		word_t target;
		logic ecall;
		logic mret;
		logic fence_i;
	} mem_stage_t;

	// writeback record
	typedef struct packed {
		reg_idx_t rd;
		logic reg_write;
		word_t wdata;
		logic taken;
		word_t target;
		logic ecall;
		logic mret;
		logic fence_i;
	} wb_t;

endpackage

// File: src/exu_top.sv
`timescale 1ns/100ps

module exu_top (
	input  logic              clk,
	input  logic              reset,
	input  logic              in_valid,
	output logic              in_ready,
	input  exu_pkg::exu_req_t in_req,
	output logic              out_valid,
	input  logic              out_ready,
	output exu_pkg::wb_t      out_wb
);

	logic ex_load;
	logic mem_load;
	logic commit;

	exu_pkg::exu_req_t ex_req; // request held in execute
	exu_pkg::mem_stage_t ex_out;
	exu_pkg::mem_stage_t mem_rec;

	exu_ctrl u_ctrl (
		.clk       (clk),
		.reset     (reset),
		.in_valid  (in_valid),
		.in_ready  (in_ready),
		.out_valid (out_valid),
		.out_ready (out_ready),
		.ex_load   (ex_load),
		.mem_load  (mem_load),
		.commit    (commit)
	);

	stage_reg #(
		.payload_t (exu_pkg::exu_req_t)
	) u_ex_reg (
		.clk   (clk),
		.reset (reset),
		.load  (ex_load),
		.d     (in_req),
		.q     (ex_req)
	);

	exu_execute u_execute (
		.req (ex_req),
		.mem (ex_out)
	);

	stage_reg #(
		.payload_t (exu_pkg::mem_stage_t)
	) u_mem_reg (
		.clk   (clk),
		.reset (reset),
		.load  (mem_load),
		.d     (ex_out),
		.q     (mem_rec)
	);

	// memory read and writeback record straight off the stage register
	lsu_dmem u_lsu (
		.clk    (clk),
		.mem    (mem_rec),
		.commit (commit),
		.wb     (out_wb)
	);

endmodule

// File: src/lsu_dmem.sv
`timescale 1ns/100ps
`include "exu_macros.svh"

module lsu_dmem (
	input  logic                clk,
	input  exu_pkg::mem_stage_t mem,
	input  logic                commit,
	output exu_pkg::wb_t        wb
);

	localparam int BYTES = `EXU_WORD_BYTES;
	localparam int OFF_W = $clog2(`EXU_WORD_BYTES);
	localparam int IDX_W = $clog2(`EXU_DMEM_WORDS);

	exu_pkg::word_t ram [0:`EXU_DMEM_WORDS-1];

	logic [IDX_W-1:0] idx;
	logic [OFF_W-1:0] off;
	logic [BYTES-1:0] byte_en;
	exu_pkg::word_t st_lanes;
	exu_pkg::word_t rd_lane;
	exu_pkg::word_t ld_val;

	assign idx = mem.result[OFF_W +: IDX_W]; // wraps over the array
	assign off = mem.result[OFF_W-1:0];

	initial begin
		for (int i = 0; i < `EXU_DMEM_WORDS; i++)
			ram[i] = '0;
	end

	// lanes shifted up by the byte offset, bytes past the word are dropped
	always_comb begin
		byte_en = '0;
		st_lanes = mem.store_data << {off, 3'b000};
		case (mem.store_kind)
			exu_pkg::ST_SB: byte_en = BYTES'(4'b0001) << off;
			exu_pkg::ST_SH: byte_en = BYTES'(4'b0011) << off;
			exu_pkg::ST_SW: byte_en = {BYTES{1'b1}} << off;
			default: byte_en = '0;
		endcase
	end

	// store lands only when the record leaves the stage
	always_ff @(posedge clk) begin
		if (commit && mem.store_kind != exu_pkg::ST_NONE) begin
			for (int i = 0; i < BYTES; i++) begin
				if (byte_en[i])
					ram[idx][8*i +: 8] <= st_lanes[8*i +: 8];
			end
		end
	end

	assign rd_lane = ram[idx] >> {off, 3'b000}; // addressed byte at bit 0

	always_comb begin
		case (mem.load_kind)
			exu_pkg::LD_LB: ld_val = {{(`EXU_XLEN-8){rd_lane[7]}}, rd_lane[7:0]};
			exu_pkg::LD_LH: ld_val = {{(`EXU_XLEN-16){rd_lane[15]}}, rd_lane[15:0]};
			exu_pkg::LD_LBU: ld_val = {{(`EXU_XLEN-8){1'b0}}, rd_lane[7:0]};
			exu_pkg::LD_LHU: ld_val = {{(`EXU_XLEN-16){1'b0}}, rd_lane[15:0]};
			exu_pkg::LD_LW: ld_val = rd_lane;
			default: ld_val = mem.result; // not a load
		endcase
	end

	assign wb.rd = mem.rd;
	assign wb.reg_write = mem.reg_write;
	assign wb.wdata = ld_val;
	assign wb.taken = mem.taken;
	assign wb.target = mem.target;
	assign wb.ecall = mem.ecall;
	assign wb.mret = mem.mret;
	assign wb.fence_i = mem.fence_i;

endmodule

// File: src/stage_reg.sv
`timescale 1ns/100ps

// one pipeline stage, payload type picked per instance
module stage_reg #(
	parameter type payload_t = logic
) (
	input  logic     clk,
	input  logic     reset,
	input  logic     load,
	input  payload_t d,
	output payload_t q
);

	always_ff @(posedge clk) begin
		if (reset) begin
			q <= '0;
		end else if (load) begin
			q <= d; // hold otherwise
		end
	end

endmodule
